// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - hw/rv_pkg.sv
      - hw/rv_fetch.sv
      - hw/rv_regfile.sv
      - hw/rv_decode.sv
      - hw/rv_execute.sv
      - hw/rv_mem_access.sv
      - hw/rv_core.sv
  - target: simulation
    files:
      - sim/rv_store_monitor.sv
      - sim/rv_core_checker.sv
      - sim/rv_core_tb.sv

// ==== hw/rv_core.sv ====
// single-cycle RV32I core, one instruction commits on every rising edge
// both memory ports must answer in the same cycle, there is no stall input

module rv_core (
  input  logic          clk,
  input  logic          rst,
  output rv_pkg::word_t imem_addr,
  input  rv_pkg::word_t imem_data,
  output rv_pkg::word_t dmem_addr,
  output rv_pkg::word_t dmem_wdata,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::strb_t dmem_strb,
  output logic          halt
);

  import rv_pkg::*;

  word_t     pc;
  word_t     target;
  logic      redirect;
  reg_idx_t  rs1_idx;
  reg_idx_t  rs2_idx;
  word_t     rs1_data;
  word_t     rs2_data;
  decoded_t  dec;
  executed_t exe;
  reg_idx_t  rd_idx;
  logic      rd_we_raw;
  word_t     rd_data;
  strb_t     strb_raw;

  assign imem_addr = pc;

  // no register or memory write may land while reset is asserted
  assign dmem_strb = rst ? '0 : strb_raw;

  rv_fetch fetch_i (
    .clk      (clk),
    .rst      (rst),
    .redirect (redirect),
    .target   (target),
    .halt     (halt),
    .pc       (pc)
  );

  rv_regfile regfile_i (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rd_idx   (rd_idx),
    .rd_we    (rd_we_raw & ~rst),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_decode decode_i (
    .pc       (pc),
    .insn     (imem_data),
    .rs1_idx  (rs1_idx),
    .rs2_idx  (rs2_idx),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dec      (dec)
  );

  rv_execute execute_i (
    .dec      (dec),
    .exe      (exe),
    .redirect (redirect),
    .target   (target)
  );

  rv_mem_access mem_access_i (
    .exe        (exe),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (strb_raw),
    .dmem_rdata (dmem_rdata),
    .rd_idx     (rd_idx),
    .rd_we      (rd_we_raw),
    .rd_data    (rd_data),
    .halt       (halt)
  );

endmodule

// ==== hw/rv_decode.sv ====
// instruction decode for RV32I
// unknown opcodes and illegal funct encodings become a no-op that writes nothing
// FENCE is a no-op, only an all-zero ECALL raises halt

module rv_decode (
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1_idx,
  output rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::decoded_t dec
);

  import rv_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  // funct3 to ALU operation, sub and sra only where the caller allows them
  function automatic alu_op_e alu_of(logic [2:0] f3, logic sub_sel, logic sra_sel);
    case (f3)
      3'b000:  return sub_sel ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return sra_sel ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  assign opcode  = opcode_e'(insn[6:0]);
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec          = '0;
    dec.rs1_val  = rs1_data;
    dec.rs2_val  = rs2_data;
    dec.pc       = pc;
    dec.rd       = insn[11:7];
    dec.alu_op   = alu_add;
    dec.branch   = br_none;
    dec.mem_op   = mem_none;
    dec.mem_size = size_word;
    case (opcode)
      op_lui: begin
        dec.we       = 1'b1;
        dec.imm      = imm_u;
        dec.b_is_imm = 1'b1;
        dec.alu_op   = alu_pass_b;
      end
      op_auipc: begin
        dec.we       = 1'b1;
        dec.imm      = imm_u;
        dec.b_is_imm = 1'b1;
        dec.alu_op   = alu_add_pc;
      end
      op_jal: begin
        dec.we     = 1'b1;
        dec.imm    = imm_j;
        dec.branch = br_jal;
      end
      op_jalr: begin
        dec.we     = 1'b1;
        dec.imm    = imm_i;
        dec.branch = br_jalr;
      end
      op_branch: begin
        dec.imm = imm_b;
        case (funct3)
          3'b000:  dec.branch = br_eq;
          3'b001:  dec.branch = br_ne;
          3'b100:  dec.branch = br_lt;
          3'b101:  dec.branch = br_ge;
          3'b110:  dec.branch = br_ltu;
          3'b111:  dec.branch = br_geu;
          default: dec.branch = br_none;
        endcase
      end
      op_load: begin
        dec.imm          = imm_i;
        dec.b_is_imm     = 1'b1;
        dec.mem_unsigned = funct3[2];
        // lb lh lw lbu lhu, anything else is dropped
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          dec.we     = 1'b1;
          dec.mem_op = mem_load;
        end
        case (funct3[1:0])
          2'b00:   dec.mem_size = size_byte;
          2'b01:   dec.mem_size = size_half;
          default: dec.mem_size = size_word;
        endcase
      end
      op_store: begin
        dec.imm      = imm_s;
        dec.b_is_imm = 1'b1;
        if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
          dec.mem_op = mem_store;
        end
        case (funct3[1:0])
          2'b00:   dec.mem_size = size_byte;
          2'b01:   dec.mem_size = size_half;
          default: dec.mem_size = size_word;
        endcase
      end
      op_op_imm: begin
        dec.imm      = imm_i;
        dec.b_is_imm = 1'b1;
        dec.alu_op   = alu_of(funct3, 1'b0, funct7[5]);
        // shift immediates carry funct7 in the upper immediate bits
        case (funct3)
          3'b001:  dec.we = (funct7 == 7'b0000000);
          3'b101:  dec.we = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          default: dec.we = 1'b1;
        endcase
      end
      op_op: begin
        dec.alu_op = alu_of(funct3, funct7[5], funct7[5]);
        dec.we     = (funct7 == 7'b0000000) ||
                     ((funct7 == 7'b0100000) && (funct3 inside {3'b000, 3'b101}));
      end
      op_system: begin
        dec.halt = (insn[31:7] == '0);
      end
      default: begin
        // FENCE and unknown encodings fall through as a no-op
      end
    endcase
  end

endmodule

// ==== hw/rv_execute.sv ====
// ALU, branch resolution and jump targets
// for loads and stores the ALU result is the byte address, alignment is handled later
// misaligned jump targets are not trapped

module rv_execute (
  input  rv_pkg::decoded_t  dec,
  output rv_pkg::executed_t exe,
  output logic              redirect,
  output rv_pkg::word_t     target
);

  import rv_pkg::*;

  word_t      op_a;
  word_t      op_b;
  word_t      alu_result;
  logic [4:0] shamt;
  logic       is_jump;
  logic       taken;

  assign op_a  = dec.rs1_val;
  assign op_b  = dec.b_is_imm ? dec.imm : dec.rs2_val;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_sll:    alu_result = op_a << shamt;
      alu_slt:    alu_result = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu:   alu_result = word_t'(op_a < op_b);
      alu_xor:    alu_result = op_a ^ op_b;
      alu_srl:    alu_result = op_a >> shamt;
      alu_sra:    alu_result = word_t'($signed(op_a) >>> shamt);
      alu_or:     alu_result = op_a | op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_pass_b: alu_result = op_b;
      alu_add_pc: alu_result = dec.pc + op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // branch compares always use both register values, never the immediate
  always_comb begin
    case (dec.branch)
      br_jal:  taken = 1'b1;
      br_jalr: taken = 1'b1;
      br_eq:   taken = (dec.rs1_val == dec.rs2_val);
      br_ne:   taken = (dec.rs1_val != dec.rs2_val);
      br_lt:   taken = ($signed(dec.rs1_val) < $signed(dec.rs2_val));
      br_ge:   taken = ($signed(dec.rs1_val) >= $signed(dec.rs2_val));
      br_ltu:  taken = (dec.rs1_val < dec.rs2_val);
      br_geu:  taken = (dec.rs1_val >= dec.rs2_val);
      default: taken = 1'b0;
    endcase
  end

  assign is_jump  = (dec.branch == br_jal) || (dec.branch == br_jalr);
  assign redirect = taken;

  always_comb begin
    if (dec.branch == br_jalr) begin
      target = (dec.rs1_val + dec.imm) & ~word_t'(1);
    end else begin
      target = dec.pc + dec.imm;
    end
  end

  always_comb begin
    exe              = '0;
    exe.alu_result   = alu_result;
    exe.rs2_val      = dec.rs2_val;
    exe.link         = dec.pc + word_t'(pc_step);
    exe.rd           = dec.rd;
    exe.we           = dec.we;
    exe.jump         = is_jump;
    exe.mem_op       = dec.mem_op;
    exe.mem_size     = dec.mem_size;
    exe.mem_unsigned = dec.mem_unsigned;
    exe.halt         = dec.halt;
  end

endmodule

// ==== hw/rv_fetch.sv ====
// program counter, starts at address zero after reset
// redirect and halt are never high together, redirect wins if they are

module rv_fetch (
  input  logic          clk,
  input  logic          rst,
  input  logic          redirect,
  input  rv_pkg::word_t target,
  input  logic          halt,
  output rv_pkg::word_t pc
);

  import rv_pkg::*;

  word_t pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0;
    end else if (redirect) begin
      pc_q <= target;
    end else if (!halt) begin
      pc_q <= pc_q + word_t'(pc_step);
    end
    // a halted core keeps pointing at its ECALL
  end

  assign pc = pc_q;

endmodule

// ==== hw/rv_mem_access.sv ====
// data port formatting and write-back selection
// halfword accesses use only address bit 1 and word accesses ignore the low bits,
// so misaligned accesses are silently rounded down

module rv_mem_access (
  input  rv_pkg::executed_t exe,
  output rv_pkg::word_t     dmem_addr,
  output rv_pkg::word_t     dmem_wdata,
  output rv_pkg::strb_t     dmem_strb,
  input  rv_pkg::word_t     dmem_rdata,
  output rv_pkg::reg_idx_t  rd_idx,
  output logic              rd_we,
  output rv_pkg::word_t     rd_data,
  output logic              halt
);

  import rv_pkg::*;

  logic [1:0] offset;
  word_t      rdata_shifted;
  word_t      load_val;

  assign offset    = exe.alu_result[1:0];
  assign dmem_addr = {exe.alu_result[xlen-1:2], 2'b00};

  // store lanes, data is replicated so the strobes alone pick the bytes
  always_comb begin
    case (exe.mem_size)
      size_byte: begin
        dmem_wdata = {4{exe.rs2_val[7:0]}};
        dmem_strb  = strb_t'(4'b0001 << offset);
      end
      size_half: begin
        dmem_wdata = {2{exe.rs2_val[15:0]}};
        dmem_strb  = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = exe.rs2_val;
        dmem_strb  = 4'b1111;
      end
    endcase
    if (exe.mem_op != mem_store) begin
      dmem_strb = '0;
    end
  end

  // bring the addressed byte or halfword down to bit 0
  assign rdata_shifted = dmem_rdata >> {offset[1], offset[0] & (exe.mem_size == size_byte), 3'b000};

  always_comb begin
    case (exe.mem_size)
      size_byte: begin
        load_val = exe.mem_unsigned ? {24'b0, rdata_shifted[7:0]}
                                    : {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
      end
      size_half: begin
        load_val = exe.mem_unsigned ? {16'b0, rdata_shifted[15:0]}
                                    : {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
      end
      default: load_val = dmem_rdata;
    endcase
  end

  always_comb begin
    if (exe.mem_op == mem_load) begin
      rd_data = load_val;
    end else if (exe.jump) begin
      rd_data = exe.link;
    end else begin
      rd_data = exe.alu_result;
    end
  end

  assign rd_idx = exe.rd;
  assign rd_we  = exe.we;
  assign halt   = exe.halt;

endmodule

// ==== hw/rv_pkg.sv ====
// shared widths, encodings and stage structs for the single-cycle RV32I core
// only the base integer ISA is encoded, there is no M extension and no CSR support

package rv_pkg;

  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_addr_w = 5;
  localparam int unsigned num_regs   = 32;
  localparam int unsigned strb_w     = 4;
  localparam int unsigned pc_step    = 4;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;
  typedef logic [strb_w-1:0]     strb_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_store    = 7'b0100011,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_misc_mem = 7'b0001111,
    op_jal      = 7'b1101111,
    op_op_imm   = 7'b0010011,
    op_op       = 7'b0110011,
    op_system   = 7'b1110011,
    op_auipc    = 7'b0010111,
    op_lui      = 7'b0110111
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b, alu_add_pc
  } alu_op_e;

  typedef enum logic [3:0] {
    br_none, br_jal, br_jalr, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu
  } branch_e;

  typedef enum logic [1:0] {mem_none, mem_load, mem_store} mem_op_e;

  typedef enum logic [1:0] {size_byte, size_half, size_word} mem_size_e;

  // decode to execute
  typedef struct packed {
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
    word_t     pc;
    reg_idx_t  rd;
    logic      we;
    alu_op_e   alu_op;
    logic      b_is_imm;
    branch_e   branch;
    mem_op_e   mem_op;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      halt;
  } decoded_t;

  // execute to memory access, jump marks the link value as the write-back source
  typedef struct packed {
    word_t     alu_result;
    word_t     rs2_val;
    word_t     link;
    reg_idx_t  rd;
    logic      we;
    logic      jump;
    mem_op_e   mem_op;
    mem_size_e mem_size;
    logic      mem_unsigned;
    logic      halt;
  } executed_t;

endpackage

// ==== hw/rv_regfile.sv ====
// 32 x 32 register file, two asynchronous reads and one write on the clock edge
// a write is not visible on the read ports until the following cycle

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  import rv_pkg::*;

  word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd_idx != '0)) begin
      // x0 is never written so it stays at its reset value of zero
      regs[rd_idx] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_idx];
  assign rs2_data = regs[rs2_idx];

endmodule

// ==== sim/rv_core_checker.sv ====
// port-level assertions for rv_core, attached by bind

module rv_core_checker (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t imem_addr,
  input rv_pkg::strb_t dmem_strb,
  input logic          halt
);

  timeunit 1ns;
  timeprecision 100ps;

  import rv_pkg::*;

  int fail_count = 0;

  strb_zero_in_reset: assert property (@(posedge clk) rst |-> dmem_strb == '0)
    else begin
      $error("store strobes active during reset");
      fail_count++;
    end

  // byte, halfword or word lanes only
  strb_legal: assert property (@(posedge clk) disable iff (rst)
    dmem_strb inside {4'h0, 4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'hf})
    else begin
      $error("illegal store strobe pattern");
      fail_count++;
    end

  fetch_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else begin
      $error("instruction address not word aligned");
      fail_count++;
    end

  halt_holds_pc: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(imem_addr))
    else begin
      $error("pc moved while halted");
      fail_count++;
    end

endmodule

bind rv_core rv_core_checker checker_i (
  .clk       (clk),
  .rst       (rst),
  .imem_addr (imem_addr),
  .dmem_strb (dmem_strb),
  .halt      (halt)
);

// ==== sim/rv_core_tb.sv ====
// testbench for the single-cycle RV32I core
// memory is 1 KB of words, program loaded from address 0, data expected at 0x200 and up
// stimulus file is read from the project root

module rv_core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import rv_pkg::*;

  localparam int unsigned mem_words = 256;

  logic  clk;
  logic  rst;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;
  strb_t dmem_strb;
  logic  halt;

  word_t mem [mem_words];
  int    prog_words;
  logic  loaded;

  rv_core dut_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .imem_data  (imem_data),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_rdata (dmem_rdata),
    .dmem_strb  (dmem_strb),
    .halt       (halt)
  );

  rv_store_monitor mon_i (
    .clk        (clk),
    .rst        (rst),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_strb  (dmem_strb),
    .halt       (halt)
  );

  always #2 clk = ~clk;

  // both ports answer in the same cycle, reads see the contents before the edge
  assign imem_data  = mem[imem_addr[9:2]];
  assign dmem_rdata = mem[dmem_addr[9:2]];

  always @(posedge clk) begin
    for (int b = 0; b < strb_w; b++) begin
      if (dmem_strb[b]) begin
        mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
      end
    end
  end

  initial begin : main
    int    fd;
    int    code;
    int    tag;
    string line;
    word_t a;
    word_t d;
    word_t s;
    int    total;

    clk        = 1'b0;
    rst        = 1'b1;
    loaded     = 1'b0;
    prog_words = 0;
    // fill depends on every address bit so a stray fetch is easy to spot
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = word_t'(i) * 32'h9e3779b1 ^ 32'h5a5a0000;
    end
    fd = $fopen("sim/rv_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file sim/rv_stimulus.txt");
      $display("Finished with errors");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", tag);
        if (code != 1) begin
          break;
        end
        if (tag == "#") begin
          code = $fgets(line, fd);
        end else if (tag == "P") begin
          code = $fscanf(fd, "%h", d);
          mem[prog_words] = d;
          prog_words++;
        end else if (tag == "S") begin
          code = $fscanf(fd, "%h %h %h", a, d, s);
          mon_i.add_store(a, d, strb_t'(s));
        end else if (tag == "H") begin
          code = $fscanf(fd, "%h", a);
          mon_i.set_halt_pc(a);
        end
      end
      $fclose(fd);
      loaded = 1'b1;

      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      while (!halt) begin
        @(negedge clk);
      end
      // let a few more cycles pass to catch anything after the ECALL
      repeat (3) @(negedge clk);
      mon_i.check_missing();

      total = mon_i.mismatch_count + mon_i.missing_count + mon_i.extra_count
            + dut_i.checker_i.fail_count;
      $display("errors: %0d total, %0d mismatches, %0d missing, %0d extra, %0d assertion",
               total, mon_i.mismatch_count, mon_i.missing_count, mon_i.extra_count,
               dut_i.checker_i.fail_count);
      if (total == 0) begin
        $display("Finished with no errors");
      end else begin
        $display("Finished with errors");
      end
      $finish;
    end
  end

  // limit grows with the program, long loops are not expected
  initial begin : watchdog
    wait (loaded);
    repeat (prog_words * 16 + 20) @(posedge clk);
    $display("timeout, the core did not halt within %0d cycles", prog_words * 16 + 20);
    $display("Finished with errors");
    $finish;
  end

endmodule

// ==== sim/rv_stimulus.txt ====
# P word: program words from address 0 | S addr data strb: expected stores in order
# H addr: expected halt pc | x1 = 0x200 data base, 0000a023 is a store that must be skipped
P 20000093
P ffb00113
P 00300193
P 40315233
P 0040a023
P 003122b3
P 00313333
P 0050a223
P 0060a423
P 01c15413
P 123454b7
P 0084c533
P 00a0a623
P 00001597
P 00b0a823
P 40218ab3
P 00319b33
P 0150aa23
P 0160ac23
P 00314463
P 0000a023
P 00316463
P 02208023
P 00315463
P 023080a3
P 00317463
P 0000a023
P 00318463
P 0000a023
P 00319463
P 02a08123
P 022081a3
P 02209223
P 02a09323
P 02008603
P 0230c683
P 02208703
P 02409783
P 0240d803
P 02609883
P 02c0a423
P 02d0a623
P 02e0a823
P 02f0aa23
P 0300ac23
P 0310ae23
P 0080096f
P 0000a023
P 0d000a13
P 001a09e7
P 0000a023
P 0000a023
P 0520a023
P 0530a223
P 0ff0000f
P 00000073
P 0000a023
S 00000200 ffffffff f
S 00000204 00000001 f
S 00000208 00000000 f
S 0000020c 1234500f f
S 00000210 00001034 f
S 00000214 00000008 f
S 00000218 00000018 f
S 00000220 fbfbfbfb 1
S 00000220 03030303 2
S 00000220 0f0f0f0f 4
S 00000220 fbfbfbfb 8
S 00000224 fffbfffb 3
S 00000224 500f500f c
S 00000228 fffffffb f
S 0000022c 000000fb f
S 00000230 0000000f f
S 00000234 fffffffb f
S 00000238 0000fffb f
S 0000023c 0000500f f
S 00000240 000000bc f
S 00000244 000000c8 f
H 000000dc

// ==== sim/rv_store_monitor.sv ====
// watches the data port and compares stores in order against the expected list
// only the strobed bytes of the data are compared
// holds up to 64 expected stores

module rv_store_monitor (
  input logic          clk,
  input logic          rst,
  input rv_pkg::word_t imem_addr,
  input rv_pkg::word_t dmem_addr,
  input rv_pkg::word_t dmem_wdata,
  input rv_pkg::strb_t dmem_strb,
  input logic          halt
);

  timeunit 1ns;
  timeprecision 100ps;

  import rv_pkg::*;

  word_t exp_addr [64];
  word_t exp_data [64];
  strb_t exp_strb [64];
  int    exp_count = 0;
  int    seen_count = 0;
  word_t halt_pc = '0;
  logic  halt_seen = 1'b0;
  logic  was_rst = 1'b1;
  int    mismatch_count = 0;
  int    missing_count = 0;
  int    extra_count = 0;

  task automatic add_store(input word_t a, input word_t d, input strb_t s);
    exp_addr[exp_count] = a;
    exp_data[exp_count] = d;
    exp_strb[exp_count] = s;
    exp_count++;
  endtask

  task automatic set_halt_pc(input word_t a);
    halt_pc = a;
  endtask

  // byte lanes selected by a strobe pattern
  function automatic word_t lane_mask(input strb_t s);
    word_t m;
    for (int b = 0; b < strb_w; b++) begin
      m[8*b +: 8] = {8{s[b]}};
    end
    return m;
  endfunction

  task automatic check_missing();
    if (seen_count < exp_count) begin
      $display("only %0d of %0d expected stores were seen", seen_count, exp_count);
      missing_count += exp_count - seen_count;
    end
    if (!halt_seen) begin
      $display("the core never raised halt");
      missing_count++;
    end
  endtask

  always @(negedge clk) begin
    // first fetch after reset must come from address zero
    if (was_rst && !rst && imem_addr != '0) begin
      $display("error at %0d ns: first fetch at %h, expected %h", $time, imem_addr, 32'h0);
      mismatch_count++;
    end
    was_rst <= rst;
    if (rst && dmem_strb != '0) begin
      $display("a store happened while reset was asserted");
      extra_count++;
    end
    if (!rst && dmem_strb != '0) begin
      if (halt_seen || seen_count >= exp_count) begin
        $display("unexpected store to %h with strobes %b", dmem_addr, dmem_strb);
        extra_count++;
      end else begin
        if (dmem_addr != exp_addr[seen_count] || dmem_strb != exp_strb[seen_count] ||
            (dmem_wdata & lane_mask(dmem_strb)) !=
            (exp_data[seen_count] & lane_mask(dmem_strb))) begin
          $display("error at %0d ns: store %0d got %h %h %b, expected %h %h %b", $time,
                   seen_count, dmem_addr, dmem_wdata, dmem_strb, exp_addr[seen_count],
                   exp_data[seen_count], exp_strb[seen_count]);
          mismatch_count++;
        end
        seen_count++;
      end
    end
    if (!rst && halt && !halt_seen) begin
      halt_seen <= 1'b1;
      if (imem_addr != halt_pc) begin
        $display("error at %0d ns: halt at %h, expected %h", $time, imem_addr, halt_pc);
        mismatch_count++;
      end
    end
  end

endmodule

// ==== verilog.f ====
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_access.sv
hw/rv_core.sv
sim/rv_store_monitor.sv
sim/rv_core_checker.sv
sim/rv_core_tb.sv
